//--- hdl/error_countdown.sv
// Error countdown timer: counts seconds of an active error from 7 down to 1
// and pulses timeout at the end of the last second
`timescale 1ns/10ps
`default_nettype none

`include "panel_defines.svh"

module error_countdown (
    input  logic                 clk,
    input  logic                 rst_n,
    input  panel_pkg::panel_err_e err_masked,
    output logic                 err_active,
    output logic [3:0]           countdown,
    output logic                 timeout
);

    localparam int TICK_W = $clog2(`PANEL_TICKS_PER_SEC);
    localparam int SEC_W  = $clog2(`PANEL_COUNT_START);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`PANEL_TICKS_PER_SEC - 1);
    localparam logic [SEC_W-1:0]  SEC_LAST  = SEC_W'(`PANEL_COUNT_START - 1);

    // Cycle position inside the current second
    logic [TICK_W-1:0] tick_cnt;
    // Whole seconds elapsed since the error started
    logic [SEC_W-1:0]  sec_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt   <= '0;
            sec_cnt    <= '0;
            err_active <= 1'b0;
            timeout    <= 1'b0;
        end else if (err_masked == panel_pkg::ERR_NONE || timeout) begin
            // Idle, and also hold off while the FSM takes the timeout
            tick_cnt   <= '0;
            sec_cnt    <= '0;
            err_active <= 1'b0;
            timeout    <= 1'b0;
        end else if (!err_active) begin
            err_active <= 1'b1;
        end else if (tick_cnt == TICK_LAST) begin
            tick_cnt <= '0;
            if (sec_cnt == SEC_LAST) begin
                // End of the seventh second
                sec_cnt    <= '0;
                err_active <= 1'b0;
                timeout    <= 1'b1;
            end else begin
                sec_cnt <= sec_cnt + 1'b1;
            end
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Digit falls back to the start value whenever the counters are clear
    assign countdown = 4'(`PANEL_COUNT_START) - 4'(sec_cnt);

endmodule

`default_nettype wire

//--- hdl/key_debounce.sv
// Push-button debouncer with a single-cycle press pulse
// on each accepted rising edge
`timescale 1ns/10ps
`default_nettype none

`include "panel_defines.svh"

module key_debounce (
    input  logic clk,
    input  logic rst_n,
    input  logic btn,
    output logic press
);

    localparam int CNT_W = $clog2(`PANEL_DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PANEL_DEBOUNCE_CYCLES - 1);

    // Run length of samples that differ from the accepted level
    logic [CNT_W-1:0] cnt;
    // Accepted (debounced) button level
    logic             level;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            level <= 1'b0;
            press <= 1'b0;
        end else begin
            press <= 1'b0;
            if (btn == level) begin
                // Glitch back to the old level restarts the count
                cnt <= '0;
            end else if (cnt == CNT_LAST) begin
                // Enough stable samples, take the new level
                cnt   <= '0;
                level <= btn;
                press <= btn;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/mode_fsm.sv
// Main mode FSM: menu to one of five modes on confirm, back on
// back or timeout, plus masking of the error input in the menu
`timescale 1ns/10ps
`default_nettype none

`include "panel_defines.svh"

module mode_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`PANEL_SW_W-1:0] dip_sw,
    input  logic                  confirm_press,
    input  logic                  back_press,
    input  logic                  timeout,
    input  panel_pkg::panel_err_e  err_code,
    output panel_pkg::panel_mode_e mode,
    output panel_pkg::panel_err_e  err_masked
);

    panel_pkg::panel_mode_e mode_next;

    // ====================
    // State register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= panel_pkg::MODE_MENU;
        end else begin
            mode <= mode_next;
        end
    end

    // ====================
    // Next-state logic
    // ====================
    always_comb begin
        mode_next = mode;
        if (mode == panel_pkg::MODE_MENU) begin
            // Switch code only matters on confirm from the menu
            if (confirm_press) begin
                case (dip_sw)
                    3'd1:    mode_next = panel_pkg::MODE_INPUT;
                    3'd2:    mode_next = panel_pkg::MODE_GENERATE;
                    3'd3:    mode_next = panel_pkg::MODE_DISPLAY;
                    3'd4:    mode_next = panel_pkg::MODE_COMPUTE;
                    3'd5:    mode_next = panel_pkg::MODE_SETTING;
                    default: mode_next = panel_pkg::MODE_MENU;
                endcase
            end
        end else if (back_press || timeout) begin
            // Confirm is ignored inside a mode
            mode_next = panel_pkg::MODE_MENU;
        end
    end

    // Menu never reports an error to the timer
    assign err_masked = (mode == panel_pkg::MODE_MENU) ? panel_pkg::ERR_NONE : err_code;

endmodule

`default_nettype wire

//--- hdl/panel_pkg.sv
// Shared front-panel types: mode and error enums,
// and the status word handed to the display decoder
`default_nettype none

`include "panel_defines.svh"

package panel_pkg;

    // ====================
    // Main modes
    // ====================

    // Encoding matches the DIP switch code that selects each mode
    typedef enum logic [`PANEL_SW_W-1:0] {
        MODE_MENU     = 3'd0,
        MODE_INPUT    = 3'd1,
        MODE_GENERATE = 3'd2,
        MODE_DISPLAY  = 3'd3,
        MODE_COMPUTE  = 3'd4,
        MODE_SETTING  = 3'd5
    } panel_mode_e;

    // ====================
    // Error codes
    // ====================

    // Any non-zero code starts the countdown
    typedef enum logic [`PANEL_ERR_W-1:0] {
        ERR_NONE  = 4'd0,
        ERR_DIM   = 4'd1,
        ERR_VALUE = 4'd2,
        ERR_COUNT = 4'd3,
        ERR_OP    = 4'd4
    } panel_err_e;

    // Everything the seven-segment decoder needs
    typedef struct packed {
        panel_mode_e mode;
        logic        err_active;
        logic [3:0]  countdown;
    } panel_status_t;

endpackage

`default_nettype wire

//--- hdl/panel_top.sv
// Front-panel top level: two button debouncers, mode FSM,
// error countdown and seven-segment decoder
`timescale 1ns/10ps
`default_nettype none

`include "panel_defines.svh"

module panel_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`PANEL_SW_W-1:0]  dip_sw,
    input  logic                    btn_confirm,
    input  logic                    btn_back,
    input  logic [`PANEL_ERR_W-1:0] err_code,
    output logic [`PANEL_SEG_W-1:0] seg_display,
    output logic [`PANEL_SEG_W-1:0] seg_countdown,
    output logic [3:0]              led_status
);

    logic                     confirm_press;
    logic                     back_press;
    logic                     timeout;
    logic                     err_active;
    logic [3:0]               countdown;
    panel_pkg::panel_mode_e   mode;
    panel_pkg::panel_err_e    err_masked;
    panel_pkg::panel_status_t status;

    // ====================
    // Buttons
    // ====================
    key_debounce db_confirm (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (btn_confirm),
        .press (confirm_press)
    );

    key_debounce db_back (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (btn_back),
        .press (back_press)
    );

    // ====================
    // Control
    // ====================
    mode_fsm u_mode_fsm (
        .clk           (clk),
        .rst_n         (rst_n),
        .dip_sw        (dip_sw),
        .confirm_press (confirm_press),
        .back_press    (back_press),
        .timeout       (timeout),
        .err_code      (panel_pkg::panel_err_e'(err_code)),
        .mode          (mode),
        .err_masked    (err_masked)
    );

    // Timeout goes straight back to the FSM
    error_countdown u_error_countdown (
        .clk        (clk),
        .rst_n      (rst_n),
        .err_masked (err_masked),
        .err_active (err_active),
        .countdown  (countdown),
        .timeout    (timeout)
    );

    // ====================
    // Display
    // ====================
    assign status = '{mode: mode, err_active: err_active, countdown: countdown};

    seg_decoder u_seg_decoder (
        .status        (status),
        .seg_display   (seg_display),
        .seg_countdown (seg_countdown),
        .led_status    (led_status)
    );

endmodule

`default_nettype wire

//--- hdl/seg_decoder.sv
// Seven-segment and LED decoding of the panel status
// Segments active high, order gfedcba
`timescale 1ns/10ps
`default_nettype none

`include "panel_defines.svh"

module seg_decoder (
    input  panel_pkg::panel_status_t  status,
    output logic [`PANEL_SEG_W-1:0]   seg_display,
    output logic [`PANEL_SEG_W-1:0]   seg_countdown,
    output logic [3:0]                led_status
);

    // Hex digit to segment pattern
    function automatic logic [`PANEL_SEG_W-1:0] hex_to_seg(input logic [3:0] digit);
        case (digit)
            4'h0:    hex_to_seg = 7'h3F;
            4'h1:    hex_to_seg = 7'h06;
            4'h2:    hex_to_seg = 7'h5B;
            4'h3:    hex_to_seg = 7'h4F;
            4'h4:    hex_to_seg = 7'h66;
            4'h5:    hex_to_seg = 7'h6D;
            4'h6:    hex_to_seg = 7'h7D;
            4'h7:    hex_to_seg = 7'h07;
            4'h8:    hex_to_seg = 7'h7F;
            4'h9:    hex_to_seg = 7'h6F;
            4'hA:    hex_to_seg = 7'h77;
            4'hB:    hex_to_seg = 7'h7C;
            4'hC:    hex_to_seg = 7'h39;
            4'hD:    hex_to_seg = 7'h5E;
            4'hE:    hex_to_seg = 7'h79;
            default: hex_to_seg = 7'h71;
        endcase
    endfunction

    // ====================
    // Digit outputs
    // ====================
    assign seg_display = hex_to_seg({1'b0, status.mode});

    // Countdown digit is dark unless an error is being timed
    assign seg_countdown = status.err_active ? hex_to_seg(status.countdown) : '0;

    // Mode code above the error flag
    assign led_status = {status.mode, status.err_active};

endmodule

`default_nettype wire

//--- include/panel_defines.svh
// Front-panel constants: countdown clock rate, debounce length,
// countdown start digit and field widths
`ifndef PANEL_DEFINES_SVH
`define PANEL_DEFINES_SVH

// ====================
// Timing
// ====================

// Clock cycles per countdown second, scaled down from the board clock
`define PANEL_TICKS_PER_SEC 32'd16

// Consecutive equal samples before a button level is accepted
`define PANEL_DEBOUNCE_CYCLES 4

// First digit of the error countdown
`define PANEL_COUNT_START 7

// ====================
// Field widths
// ====================
`define PANEL_ERR_W 4
`define PANEL_SW_W 3
`define PANEL_SEG_W 7

`endif

//--- project.f
+incdir+include
hdl/panel_pkg.sv
hdl/key_debounce.sv
hdl/mode_fsm.sv
hdl/error_countdown.sv
hdl/seg_decoder.sv
hdl/panel_top.sv
tests/panel_chk.sv
tests/panel_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the front-panel testbench with Verilator, run it, then look for the pass message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module panel_tb -o panel_sim \
    || { echo "Verilator build failed"; exit 1; }

# Keep running past assertion errors so the testbench can print its verdict
./obj_dir/panel_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log && echo "Simulation PASS" && exit 0 \
    || { echo "Simulation FAIL"; exit 1; }

//--- tests/panel_chk.sv
// Concurrent assertions on the front-panel top level: press and timeout
// pulse widths, legal mode encoding, no error flag in the menu
`timescale 1ns/10ps
`default_nettype none

`include "panel_defines.svh"

module panel_chk (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   confirm_press,
    input logic                   back_press,
    input logic                   timeout,
    input logic [`PANEL_SW_W-1:0] mode,
    input logic                   err_active
);

    // Failure tallies, read by the testbench at the end of the run
    int confirm_fails;
    int back_fails;
    int timeout_fails;
    int mode_fails;
    int menu_fails;
    int fail_count;

    assign fail_count = confirm_fails + back_fails + timeout_fails + mode_fails + menu_fails;

    // ====================
    // Pulse widths
    // ====================
    confirm_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        confirm_press |=> !confirm_press)
        else begin
            confirm_fails++;
            $error("confirm_press stayed high for more than one cycle");
        end

    back_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        back_press |=> !back_press)
        else begin
            back_fails++;
            $error("back_press stayed high for more than one cycle");
        end

    timeout_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        timeout |=> !timeout)
        else begin
            timeout_fails++;
            $error("timeout stayed high for more than one cycle");
        end

    // ====================
    // Mode and error state
    // ====================
    mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
        mode <= 3'd5)
        else begin
            mode_fails++;
            $error("mode holds an undefined code");
        end

    menu_no_error: assert property (@(posedge clk) disable iff (!rst_n)
        (mode == panel_pkg::MODE_MENU) |-> !err_active)
        else begin
            menu_fails++;
            $error("err_active is high while in the menu");
        end

endmodule

bind panel_top panel_chk chk0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .confirm_press (confirm_press),
    .back_press    (back_press),
    .timeout       (timeout),
    .mode          (mode),
    .err_active    (err_active)
);

`default_nettype wire

//--- tests/panel_tb.sv
// Testbench for the front-panel top level: clock, reset, button and
// error stimulus, mode model, reference outputs, compare and run timeout
`timescale 1ns/10ps
`default_nettype none

`include "panel_defines.svh"

module panel_tb;

    localparam int DB          = `PANEL_DEBOUNCE_CYCLES;
    localparam int TPS         = `PANEL_TICKS_PER_SEC;
    localparam int SETTLE      = DB + 3;
    localparam int PRESS_PHASE = 2 * SETTLE;
    localparam int ERROR_PHASE = `PANEL_COUNT_START * TPS + 4;
    localparam int N_PRESS     = 30;
    localparam int N_ERROR     = 3;
    localparam int CYCLE_LIMIT = 20 * (N_PRESS * PRESS_PHASE + N_ERROR * ERROR_PHASE);

    logic                    clk;
    logic                    rst_n;
    logic [`PANEL_SW_W-1:0]  dip_sw;
    logic                    btn_confirm;
    logic                    btn_back;
    logic [`PANEL_ERR_W-1:0] err_code;
    logic [`PANEL_SEG_W-1:0] seg_display;
    logic [`PANEL_SEG_W-1:0] seg_countdown;
    logic [3:0]              led_status;

    // Expected panel state, compared while check_en is high
    logic [2:0] exp_mode;
    logic       exp_err;
    logic [3:0] exp_count;
    logic       check_en;
    int         error_count;
    int         cycle_count;

    panel_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .dip_sw        (dip_sw),
        .btn_confirm   (btn_confirm),
        .btn_back      (btn_back),
        .err_code      (err_code),
        .seg_display   (seg_display),
        .seg_countdown (seg_countdown),
        .led_status    (led_status)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================

    // Segment patterns, gfedcba active high
    function automatic logic [6:0] digit_segments(input logic [3:0] d);
        case (d)
            4'd0:    return 7'h3F;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5B;
            4'd3:    return 7'h4F;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6D;
            4'd6:    return 7'h7D;
            4'd7:    return 7'h07;
            default: return 7'h00;
        endcase
    endfunction

    // Packed as {seg_display, seg_countdown, led_status}
    function automatic logic [17:0] expected_outputs(input logic [2:0] mode, input logic err,
                                                     input logic [3:0] cnt);
        logic [6:0] disp;
        logic [6:0] cd;
        logic [3:0] led;
        disp = digit_segments({1'b0, mode});
        cd   = err ? digit_segments(cnt) : 7'h00;
        led  = {mode, err};
        return {disp, cd, led};
    endfunction

    // Mode FSM rules: switch code only counts on confirm from the menu
    function automatic logic [2:0] model_next_mode(input logic [2:0] mode, input logic [2:0] sw,
                                                   input logic confirm, input logic back);
        if (mode == 3'd0) begin
            if (confirm && sw >= 3'd1 && sw <= 3'd5) begin
                return sw;
            end
            return mode;
        end
        if (back) begin
            return 3'd0;
        end
        return mode;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic compare_outputs();
        logic [17:0] exp;
        exp = expected_outputs(exp_mode, exp_err, exp_count);
        check_value("seg_display", 32'(seg_display), 32'(exp[17:11]));
        check_value("seg_countdown", 32'(seg_countdown), 32'(exp[10:4]));
        check_value("led_status", 32'(led_status), 32'(exp[3:0]));
    endtask

    // Compare at the falling edge, away from the input updates
    always @(negedge clk) begin
        if (check_en) begin
            compare_outputs();
        end
    end

    // ====================
    // Stimulus helpers
    // ====================
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic press_button(input logic use_back, input int hold);
        check_en = 1'b0;
        if (use_back) begin
            btn_back = 1'b1;
        end else begin
            btn_confirm = 1'b1;
        end
        step(hold);
        btn_back    = 1'b0;
        btn_confirm = 1'b0;
        exp_mode    = model_next_mode(exp_mode, dip_sw, !use_back, use_back);
        step(SETTLE);
        check_en = 1'b1;
        step(2);
    endtask

    // Too short to pass the debouncer, outputs stay compared throughout
    task automatic glitch_button(input logic use_back);
        int len;
        len = int'($urandom_range(DB - 1, 1));
        if (use_back) begin
            btn_back = 1'b1;
        end else begin
            btn_confirm = 1'b1;
        end
        step(len);
        btn_back    = 1'b0;
        btn_confirm = 1'b0;
        step(SETTLE);
    endtask

    // Hold an error until the panel falls back to the menu
    task automatic run_error_countdown(input logic [3:0] code);
        int   n;
        int   digit;
        logic seen;
        logic back_in_menu;
        check_en     = 1'b0;
        err_code     = code;
        digit        = `PANEL_COUNT_START;
        seen         = 1'b0;
        back_in_menu = 1'b0;
        for (n = 0; n < ERROR_PHASE && !back_in_menu; n++) begin
            @(negedge clk);
            if (led_status[3:1] == 3'd0) begin
                back_in_menu = 1'b1;
            end else if (led_status[0]) begin
                check_value("led_status", 32'(led_status), 32'({exp_mode, 1'b1}));
                if (!seen) begin
                    check_value("seg_countdown", 32'(seg_countdown),
                                32'(digit_segments(4'(digit))));
                    seen = 1'b1;
                end else if (seg_countdown != digit_segments(4'(digit))) begin
                    // Only a step of one digit down is allowed
                    if (digit > 1 && seg_countdown == digit_segments(4'(digit - 1))) begin
                        digit--;
                    end else begin
                        check_value("seg_countdown", 32'(seg_countdown),
                                    32'(digit_segments(4'(digit))));
                    end
                end
            end
        end
        if (!back_in_menu) begin
            error_count++;
            $display("Error: panel stayed in mode %0d after the countdown ended", exp_mode);
        end
        if (!seen || digit != 1) begin
            error_count++;
            $display("Error: countdown stopped at digit %0d instead of running down to 1", digit);
        end
        exp_mode = 3'd0;
        step(1);
        // Error still present, but masked in the menu
        check_en = 1'b1;
        step(4);
        err_code = '0;
        step(2);
    endtask

    task automatic clear_error_early(input logic [3:0] code);
        check_en = 1'b0;
        err_code = code;
        // Lands inside the third second of the error
        step(2 * TPS + 3);
        exp_err   = 1'b1;
        exp_count = 4'(`PANEL_COUNT_START - 2);
        compare_outputs();
        exp_err   = 1'b0;
        exp_count = 4'(`PANEL_COUNT_START);
        err_code  = '0;
        step(2);
        check_en = 1'b1;
        step(3);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        int code;
        rst_n       = 1'b0;
        dip_sw      = '0;
        btn_confirm = 1'b0;
        btn_back    = 1'b0;
        err_code    = '0;
        exp_mode    = 3'd0;
        exp_err     = 1'b0;
        exp_count   = 4'(`PANEL_COUNT_START);
        check_en    = 1'b0;
        error_count = 0;
        void'($urandom(32'h65c19942));

        step(3);
        rst_n    = 1'b1;
        check_en = 1'b1;
        step(3);

        // Every switch code from the menu, then back
        for (code = 0; code < 8; code++) begin
            dip_sw = 3'(code);
            step(1);
            press_button(1'b0, SETTLE);
            press_button(1'b1, SETTLE);
        end

        // Short glitches, one long hold, confirm inside a mode
        dip_sw = 3'd1;
        step(1);
        repeat (3) glitch_button(1'b0);
        press_button(1'b0, 10 * DB);
        // Back glitches while a mode is active
        repeat (3) glitch_button(1'b1);
        dip_sw = 3'($urandom_range(5, 2));
        step(1);
        press_button(1'b0, SETTLE);
        press_button(1'b1, SETTLE);

        // Error code raised in the menu
        err_code = 4'($urandom_range(4, 1));
        step(2 * TPS);
        err_code = '0;
        step(2);

        // Full countdown back to the menu
        dip_sw = 3'($urandom_range(5, 1));
        step(1);
        press_button(1'b0, SETTLE);
        run_error_countdown(4'($urandom_range(4, 1)));

        // Error cleared halfway
        dip_sw = 3'($urandom_range(5, 1));
        step(1);
        press_button(1'b0, SETTLE);
        clear_error_early(4'($urandom_range(4, 1)));
        press_button(1'b1, SETTLE);

        check_en = 1'b0;
        step(2);
        error_count += dut0.chk0.fail_count;
        $display("Run complete: %0d errors in %0d cycles", error_count, cycle_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
